/* src/oc_pkg.sv */
package oc_pkg;

    localparam int LANE_W    = 32;
    localparam int NUM_BANKS = 4;
    localparam int NUM_CU    = 4;
    localparam int WARP_W    = 3;               // eight warps
    localparam int REG_W     = 3;               // eight regs per warp
    localparam int ROW_W     = 4;
    localparam int BANK_W    = $clog2(NUM_BANKS);
    localparam int SLOTS     = NUM_CU * 2;      // two sources per unit

    typedef enum logic [1:0] {
        op_alu,
        op_load,
        op_store
    } op_t;

    typedef enum logic [1:0] {
        cu_free,
        cu_collect,
        cu_ready
    } cu_state_t;

    // consecutive regs of a warp land in different banks,
    // and the warp number skews the start bank
    function automatic logic [BANK_W-1:0] bank_of(input logic [WARP_W-1:0] warp,
                                                  input logic [REG_W-1:0] rnum);
        logic [REG_W-1:0] sum;
        sum = rnum + warp;
        return sum[BANK_W-1:0];                 // modulo 4
    endfunction

    function automatic logic [ROW_W-1:0] row_of(input logic [WARP_W-1:0] warp,
                                                input logic [REG_W-1:0] rnum);
        return {warp, rnum[REG_W-1]};
    endfunction

endpackage

/* src/reg_banks.sv */
module reg_banks #(
    parameter int NUM_LANES = 4
) (
    input  logic clk,

    input  logic [oc_pkg::SLOTS-1:0] req_valid,
    input  logic [oc_pkg::SLOTS*oc_pkg::BANK_W-1:0] req_bank,
    input  logic [oc_pkg::SLOTS*oc_pkg::ROW_W-1:0] req_row,
    output logic [oc_pkg::SLOTS-1:0] grant,
    output logic [oc_pkg::SLOTS-1:0] rd_done,
    output logic [oc_pkg::NUM_BANKS-1:0][NUM_LANES*oc_pkg::LANE_W-1:0] bank_data,

    input  logic wb_en,
    input  logic [oc_pkg::WARP_W-1:0] wb_warp,
    input  logic [oc_pkg::REG_W-1:0] wb_reg,
    input  logic [NUM_LANES-1:0] wb_mask,
    input  logic [NUM_LANES*oc_pkg::LANE_W-1:0] wb_data
);

    localparam int DW   = NUM_LANES * oc_pkg::LANE_W;
    localparam int BW   = oc_pkg::BANK_W;
    localparam int RW   = oc_pkg::ROW_W;
    localparam int ROWS = 1 << RW;

    logic [DW-1:0] mem [oc_pkg::NUM_BANKS][ROWS];

    logic [BW-1:0] wb_bank;
    logic [RW-1:0] wb_row;
    logic [oc_pkg::NUM_BANKS-1:0] rd_en;        // bank taken by a read this cycle
    logic [oc_pkg::NUM_BANKS-1:0][RW-1:0] rd_row;

    assign wb_bank = oc_pkg::bank_of(wb_warp, wb_reg);
    assign wb_row  = oc_pkg::row_of(wb_warp, wb_reg);

    // per bank, lowest slot wins; write-back blocks the bank
    always_comb begin
        grant  = '0;
        rd_en  = '0;
        rd_row = '0;
        for (int b = 0; b < oc_pkg::NUM_BANKS; b++) begin
            for (int s = 0; s < oc_pkg::SLOTS; s++) begin
                if (!rd_en[b] && !(wb_en && wb_bank == BW'(b)) && req_valid[s]
                    && req_bank[s*BW +: BW] == BW'(b)) begin
                    grant[s]  = 1'b1;
                    rd_en[b]  = 1'b1;
                    rd_row[b] = req_row[s*RW +: RW];
                end
            end
        end
    end

    // lane-masked write-back
    always_ff @(posedge clk) begin
        if (wb_en) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (wb_mask[l]) begin
                    mem[wb_bank][wb_row][l*oc_pkg::LANE_W +: oc_pkg::LANE_W] <=
                        wb_data[l*oc_pkg::LANE_W +: oc_pkg::LANE_W];
                end
            end
        end
    end

    // read data and done flags one cycle after grant
    always_ff @(posedge clk) begin
        rd_done <= grant;
        for (int b = 0; b < oc_pkg::NUM_BANKS; b++) begin
            if (rd_en[b]) begin
                bank_data[b] <= mem[b][rd_row[b]];  // no write to this bank now
            end
        end
    end

endmodule

/* src/collector_units.sv */
module collector_units #(
    parameter int NUM_LANES = 4
) (
    input  logic clk,
    input  logic rst,

    input  logic in_valid,
    input  logic [oc_pkg::WARP_W-1:0] in_warp,
    input  oc_pkg::op_t in_op,
    input  logic [oc_pkg::REG_W-1:0] in_src1,
    input  logic in_src1_valid,
    input  logic [oc_pkg::REG_W-1:0] in_src2,
    input  logic in_src2_valid,
    input  logic [oc_pkg::REG_W-1:0] in_dst,
    output logic full,

    output logic [oc_pkg::SLOTS-1:0] req_valid,
    output logic [oc_pkg::SLOTS*oc_pkg::BANK_W-1:0] req_bank,
    output logic [oc_pkg::SLOTS*oc_pkg::ROW_W-1:0] req_row,
    input  logic [oc_pkg::SLOTS-1:0] grant,
    input  logic [oc_pkg::SLOTS-1:0] rd_done,
    input  logic [oc_pkg::NUM_BANKS-1:0][NUM_LANES*oc_pkg::LANE_W-1:0] bank_data,

    input  logic [oc_pkg::NUM_CU-1:0] cu_release,
    output logic [oc_pkg::NUM_CU-1:0] cu_ready,
    output oc_pkg::op_t [oc_pkg::NUM_CU-1:0] cu_op,
    output logic [oc_pkg::NUM_CU-1:0][oc_pkg::WARP_W-1:0] cu_warp,
    output logic [oc_pkg::NUM_CU-1:0][oc_pkg::REG_W-1:0] cu_dst,
    output logic [oc_pkg::NUM_CU-1:0][NUM_LANES*oc_pkg::LANE_W-1:0] cu_src1_data,
    output logic [oc_pkg::NUM_CU-1:0][NUM_LANES*oc_pkg::LANE_W-1:0] cu_src2_data
);

    localparam int DW = NUM_LANES * oc_pkg::LANE_W;
    localparam int BW = oc_pkg::BANK_W;
    localparam int RW = oc_pkg::ROW_W;

    oc_pkg::cu_state_t state [oc_pkg::NUM_CU];

    logic [oc_pkg::NUM_CU-1:0] free;
    logic [oc_pkg::NUM_CU-1:0] alloc;           // one-hot, lowest free unit
    logic accept;

    logic [oc_pkg::SLOTS-1:0] pend;             // source still needs data
    logic [oc_pkg::SLOTS-1:0] reqd;             // granted, waiting for rd_done
    logic [oc_pkg::SLOTS-1:0] cap;
    logic [oc_pkg::SLOTS-1:0] got;
    logic [oc_pkg::SLOTS-1:0][oc_pkg::REG_W-1:0] src_reg;
    logic [oc_pkg::SLOTS-1:0][DW-1:0] src_data;

    assign alloc  = free & (~free + 1'b1);
    assign full   = ~|free;
    assign accept = in_valid && !full;
    assign cap    = rd_done & reqd;
    assign got    = ~pend | cap;

    always_comb begin
        for (int u = 0; u < oc_pkg::NUM_CU; u++) begin
            free[u]         = (state[u] == oc_pkg::cu_free);
            cu_ready[u]     = (state[u] == oc_pkg::cu_ready);
            cu_src1_data[u] = src_data[2*u];
            cu_src2_data[u] = src_data[2*u+1];
        end
        for (int s = 0; s < oc_pkg::SLOTS; s++) begin
            req_valid[s]          = pend[s] && !reqd[s];    // keep asking until granted
            req_bank[s*BW +: BW]  = oc_pkg::bank_of(cu_warp[s/2], src_reg[s]);
            req_row[s*RW +: RW]   = oc_pkg::row_of(cu_warp[s/2], src_reg[s]);
        end
    end

    always_ff @(posedge clk) begin
        for (int u = 0; u < oc_pkg::NUM_CU; u++) begin
            if (accept && alloc[u]) begin
                cu_op[u]        <= in_op;
                cu_warp[u]      <= in_warp;
                cu_dst[u]       <= in_dst;
                src_reg[2*u]    <= in_src1;
                src_reg[2*u+1]  <= in_src2;
                if (!in_src1_valid)
                    src_data[2*u] <= '0;            // unused source reads as zero
                if (!in_src2_valid)
                    src_data[2*u+1] <= '0;
            end
        end
        for (int s = 0; s < oc_pkg::SLOTS; s++) begin
            if (cap[s])
                src_data[s] <= bank_data[req_bank[s*BW +: BW]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int u = 0; u < oc_pkg::NUM_CU; u++)
                state[u] <= oc_pkg::cu_free;
            pend <= '0;
            reqd <= '0;
        end else begin
            for (int u = 0; u < oc_pkg::NUM_CU; u++) begin
                case (state[u])
                    oc_pkg::cu_free: begin
                        if (accept && alloc[u]) begin
                            state[u]     <= oc_pkg::cu_collect;
                            pend[2*u]    <= in_src1_valid;
                            pend[2*u+1]  <= in_src2_valid;
                        end
                    end
                    oc_pkg::cu_collect: begin
                        if (got[2*u] && got[2*u+1])
                            state[u] <= oc_pkg::cu_ready;
                    end
                    oc_pkg::cu_ready: begin
                        if (cu_release[u])
                            state[u] <= oc_pkg::cu_free;
                    end
                    default: state[u] <= oc_pkg::cu_free;
                endcase
            end
            for (int s = 0; s < oc_pkg::SLOTS; s++) begin
                if (grant[s])
                    reqd[s] <= 1'b1;
                if (cap[s]) begin
                    pend[s] <= 1'b0;
                    reqd[s] <= 1'b0;
                end
            end
        end
    end

endmodule

/* src/dispatch_unit.sv */
module dispatch_unit #(
    parameter int NUM_LANES = 4
) (
    input  logic clk,
    input  logic rst,

    input  logic [oc_pkg::NUM_CU-1:0] cu_ready,
    input  oc_pkg::op_t [oc_pkg::NUM_CU-1:0] cu_op,
    input  logic [oc_pkg::NUM_CU-1:0][oc_pkg::WARP_W-1:0] cu_warp,
    input  logic [oc_pkg::NUM_CU-1:0][oc_pkg::REG_W-1:0] cu_dst,
    input  logic [oc_pkg::NUM_CU-1:0][NUM_LANES*oc_pkg::LANE_W-1:0] cu_src1_data,
    input  logic [oc_pkg::NUM_CU-1:0][NUM_LANES*oc_pkg::LANE_W-1:0] cu_src2_data,
    output logic [oc_pkg::NUM_CU-1:0] cu_release,

    output logic alu_valid,
    output logic [oc_pkg::WARP_W-1:0] alu_warp,
    output logic [oc_pkg::REG_W-1:0] alu_dst,
    output logic [NUM_LANES*oc_pkg::LANE_W-1:0] alu_src1,
    output logic [NUM_LANES*oc_pkg::LANE_W-1:0] alu_src2,

    output logic mem_valid,
    output oc_pkg::op_t mem_op,
    output logic [oc_pkg::WARP_W-1:0] mem_warp,
    output logic [oc_pkg::REG_W-1:0] mem_dst,
    output logic [NUM_LANES*oc_pkg::LANE_W-1:0] mem_src1,
    output logic [NUM_LANES*oc_pkg::LANE_W-1:0] mem_src2
);

    localparam int CU_W = $clog2(oc_pkg::NUM_CU);

    logic [CU_W-1:0] alu_ptr, mem_ptr;          // rotating priority start
    logic [CU_W-1:0] alu_sel, mem_sel;
    logic [CU_W-1:0] a_idx, m_idx;
    logic alu_hit, mem_hit;

    always_comb begin
        alu_hit    = 1'b0;
        mem_hit    = 1'b0;
        alu_sel    = '0;
        mem_sel    = '0;
        a_idx      = '0;
        m_idx      = '0;
        cu_release = '0;
        for (int i = 0; i < oc_pkg::NUM_CU; i++) begin
            a_idx = alu_ptr + CU_W'(i);             // wraps since NUM_CU is a power of two
            m_idx = mem_ptr + CU_W'(i);
            if (!alu_hit && cu_ready[a_idx] && cu_op[a_idx] == oc_pkg::op_alu) begin
                alu_hit = 1'b1;
                alu_sel = a_idx;
            end
            if (!mem_hit && cu_ready[m_idx] && cu_op[m_idx] != oc_pkg::op_alu) begin
                mem_hit = 1'b1;
                mem_sel = m_idx;
            end
        end
        if (alu_hit)
            cu_release[alu_sel] = 1'b1;
        if (mem_hit)
            cu_release[mem_sel] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid <= 1'b0;
            mem_valid <= 1'b0;
            alu_ptr   <= '0;
            mem_ptr   <= '0;
        end else begin
            alu_valid <= alu_hit;
            mem_valid <= mem_hit;
            if (alu_hit)
                alu_ptr <= alu_sel + 1'b1;          // winner goes to the back
            if (mem_hit)
                mem_ptr <= mem_sel + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_hit) begin
            alu_warp <= cu_warp[alu_sel];
            alu_dst  <= cu_dst[alu_sel];
            alu_src1 <= cu_src1_data[alu_sel];
            alu_src2 <= cu_src2_data[alu_sel];
        end
        if (mem_hit) begin
            mem_op   <= cu_op[mem_sel];             // load or store
            mem_warp <= cu_warp[mem_sel];
            mem_dst  <= cu_dst[mem_sel];
            mem_src1 <= cu_src1_data[mem_sel];
            mem_src2 <= cu_src2_data[mem_sel];
        end
    end

endmodule

/* src/operand_collector.sv */
module operand_collector #(
    parameter int NUM_LANES = 4
) (
    input  logic clk,
    input  logic rst,

    input  logic in_valid,
    input  logic [oc_pkg::WARP_W-1:0] in_warp,
    input  oc_pkg::op_t in_op,
    input  logic [oc_pkg::REG_W-1:0] in_src1,
    input  logic in_src1_valid,
    input  logic [oc_pkg::REG_W-1:0] in_src2,
    input  logic in_src2_valid,
    input  logic [oc_pkg::REG_W-1:0] in_dst,
    output logic full,

    input  logic wb_en,
    input  logic [oc_pkg::WARP_W-1:0] wb_warp,
    input  logic [oc_pkg::REG_W-1:0] wb_reg,
    input  logic [NUM_LANES-1:0] wb_mask,
    input  logic [NUM_LANES*oc_pkg::LANE_W-1:0] wb_data,

    output logic alu_valid,
    output logic [oc_pkg::WARP_W-1:0] alu_warp,
    output logic [oc_pkg::REG_W-1:0] alu_dst,
    output logic [NUM_LANES*oc_pkg::LANE_W-1:0] alu_src1,
    output logic [NUM_LANES*oc_pkg::LANE_W-1:0] alu_src2,

    output logic mem_valid,
    output oc_pkg::op_t mem_op,
    output logic [oc_pkg::WARP_W-1:0] mem_warp,
    output logic [oc_pkg::REG_W-1:0] mem_dst,
    output logic [NUM_LANES*oc_pkg::LANE_W-1:0] mem_src1,
    output logic [NUM_LANES*oc_pkg::LANE_W-1:0] mem_src2
);

    localparam int DW = NUM_LANES * oc_pkg::LANE_W;

    // bank request path
    logic [oc_pkg::SLOTS-1:0] req_valid;
    logic [oc_pkg::SLOTS*oc_pkg::BANK_W-1:0] req_bank;
    logic [oc_pkg::SLOTS*oc_pkg::ROW_W-1:0] req_row;
    logic [oc_pkg::SLOTS-1:0] grant;
    logic [oc_pkg::SLOTS-1:0] rd_done;
    logic [oc_pkg::NUM_BANKS-1:0][DW-1:0] bank_data;

    // collector to dispatch
    logic [oc_pkg::NUM_CU-1:0] cu_release;
    logic [oc_pkg::NUM_CU-1:0] cu_ready;
    oc_pkg::op_t [oc_pkg::NUM_CU-1:0] cu_op;
    logic [oc_pkg::NUM_CU-1:0][oc_pkg::WARP_W-1:0] cu_warp;
    logic [oc_pkg::NUM_CU-1:0][oc_pkg::REG_W-1:0] cu_dst;
    logic [oc_pkg::NUM_CU-1:0][DW-1:0] cu_src1_data;
    logic [oc_pkg::NUM_CU-1:0][DW-1:0] cu_src2_data;

    reg_banks #(.NUM_LANES(NUM_LANES)) u_banks (
        .clk(clk),
        .req_valid(req_valid),
        .req_bank(req_bank),
        .req_row(req_row),
        .grant(grant),
        .rd_done(rd_done),
        .bank_data(bank_data),
        .wb_en(wb_en),
        .wb_warp(wb_warp),
        .wb_reg(wb_reg),
        .wb_mask(wb_mask),
        .wb_data(wb_data)
    );

    collector_units #(.NUM_LANES(NUM_LANES)) u_collect (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .in_warp(in_warp),
        .in_op(in_op),
        .in_src1(in_src1),
        .in_src1_valid(in_src1_valid),
        .in_src2(in_src2),
        .in_src2_valid(in_src2_valid),
        .in_dst(in_dst),
        .full(full),
        .req_valid(req_valid),
        .req_bank(req_bank),
        .req_row(req_row),
        .grant(grant),
        .rd_done(rd_done),
        .bank_data(bank_data),
        .cu_release(cu_release),
        .cu_ready(cu_ready),
        .cu_op(cu_op),
        .cu_warp(cu_warp),
        .cu_dst(cu_dst),
        .cu_src1_data(cu_src1_data),
        .cu_src2_data(cu_src2_data)
    );

    dispatch_unit #(.NUM_LANES(NUM_LANES)) u_dispatch (
        .clk(clk),
        .rst(rst),
        .cu_ready(cu_ready),
        .cu_op(cu_op),
        .cu_warp(cu_warp),
        .cu_dst(cu_dst),
        .cu_src1_data(cu_src1_data),
        .cu_src2_data(cu_src2_data),
        .cu_release(cu_release),
        .alu_valid(alu_valid),
        .alu_warp(alu_warp),
        .alu_dst(alu_dst),
        .alu_src1(alu_src1),
        .alu_src2(alu_src2),
        .mem_valid(mem_valid),
        .mem_op(mem_op),
        .mem_warp(mem_warp),
        .mem_dst(mem_dst),
        .mem_src1(mem_src1),
        .mem_src2(mem_src2)
    );

endmodule

/* sim/tb_operand_collector.sv */
module tb_operand_collector;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_LANES = 4;
    localparam int DW        = NUM_LANES * oc_pkg::LANE_W;
    localparam int WAIT_MAX  = 200;             // cycles before a wait gives up

    logic clk;
    logic rst;
    logic in_valid;
    logic [oc_pkg::WARP_W-1:0] in_warp;
    oc_pkg::op_t in_op;
    logic [oc_pkg::REG_W-1:0] in_src1;
    logic in_src1_valid;
    logic [oc_pkg::REG_W-1:0] in_src2;
    logic in_src2_valid;
    logic [oc_pkg::REG_W-1:0] in_dst;
    logic full;
    logic wb_en;
    logic [oc_pkg::WARP_W-1:0] wb_warp;
    logic [oc_pkg::REG_W-1:0] wb_reg;
    logic [NUM_LANES-1:0] wb_mask;
    logic [DW-1:0] wb_data;
    logic alu_valid;
    logic [oc_pkg::WARP_W-1:0] alu_warp;
    logic [oc_pkg::REG_W-1:0] alu_dst;
    logic [DW-1:0] alu_src1;
    logic [DW-1:0] alu_src2;
    logic mem_valid;
    oc_pkg::op_t mem_op;
    logic [oc_pkg::WARP_W-1:0] mem_warp;
    logic [oc_pkg::REG_W-1:0] mem_dst;
    logic [DW-1:0] mem_src1;
    logic [DW-1:0] mem_src2;

    int exp_port[$];                            // 0 alu, 1 mem
    int exp_warp[$];
    int exp_dst[$];
    int exp_op[$];
    logic [DW-1:0] exp_src1[$];
    logic [DW-1:0] exp_src2[$];

    int value_errs = 0;
    int stray_errs = 0;
    int timeouts   = 0;
    int other_errs = 0;
    int accepted   = 0;
    int dispatched = 0;
    bit aborted    = 1'b0;
    bit issued_any = 1'b0;
    bit full_seen  = 1'b0;

    operand_collector #(.NUM_LANES(NUM_LANES)) i_operand_collector (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_dispatch(input int port, input int warp, input int dst, input int op,
                                  input logic [DW-1:0] s1, input logic [DW-1:0] s2);
        int idx;
        idx = -1;
        for (int i = 0; i < exp_warp.size(); i++) begin
            if (idx < 0 && exp_warp[i] == warp && exp_dst[i] == dst)
                idx = i;                        // matched by warp and dst rather than order
        end
        assert (idx >= 0) else begin
            $display("error at %0t: unexpected dispatch, port %0d warp %0d dst %0d",
                     $time, port, warp, dst);
            stray_errs++;
        end
        if (idx >= 0) begin
            assert (exp_port[idx] == port && exp_op[idx] == op
                    && exp_src1[idx] == s1 && exp_src2[idx] == s2) else begin
                $display("error at %0t: warp %0d dst %0d got port %0d op %0d src1 %h src2 %h",
                         $time, warp, dst, port, op, s1, s2);
                value_errs++;
            end
            exp_port.delete(idx);
            exp_warp.delete(idx);
            exp_dst.delete(idx);
            exp_op.delete(idx);
            exp_src1.delete(idx);
            exp_src2.delete(idx);
        end
    endtask

    // instruction taken at this edge
    always @(posedge clk) begin
        if (in_valid && !full)
            accepted++;
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (!issued_any) begin
                assert (!full && !alu_valid && !mem_valid) else begin
                    $display("error at %0t: full or a port active before any instruction",
                             $time);
                    value_errs++;
                end
            end
            if (alu_valid)
                dispatched++;
            if (mem_valid)
                dispatched++;
            assert (full == (accepted - dispatched >= oc_pkg::NUM_CU)) else begin
                $display("error at %0t: full is %0b with %0d instructions held",
                         $time, full, accepted - dispatched);
                value_errs++;
            end
            if (full)
                full_seen = 1'b1;
            if (alu_valid)
                check_dispatch(0, alu_warp, alu_dst, oc_pkg::op_alu, alu_src1, alu_src2);
            if (mem_valid)
                check_dispatch(1, mem_warp, mem_dst, int'(mem_op), mem_src1, mem_src2);
        end
    end

    task automatic write_register(input int warp, input int rnum,
                                  input logic [NUM_LANES-1:0] mask, input logic [DW-1:0] data);
        @(negedge clk);
        in_valid = 1'b0;
        wb_en    = 1'b1;
        wb_warp  = warp[oc_pkg::WARP_W-1:0];
        wb_reg   = rnum[oc_pkg::REG_W-1:0];
        wb_mask  = mask;
        wb_data  = data;
    endtask

    task automatic issue_instr(input int warp, input int op, input int s1, input int v1,
                               input int s2, input int v2, input int dst);
        int waited;
        waited = 0;
        @(negedge clk);
        in_valid = 1'b0;
        wb_en    = 1'b0;
        while (full && waited < WAIT_MAX) begin
            @(negedge clk);
            waited++;
        end
        if (full) begin
            $display("timeout: full stayed high for %0d cycles", WAIT_MAX);
            timeouts++;
            aborted = 1'b1;
        end else begin
            issued_any    = 1'b1;
            in_valid      = 1'b1;
            in_warp       = warp[oc_pkg::WARP_W-1:0];
            in_op         = oc_pkg::op_t'(op);
            in_src1       = s1[oc_pkg::REG_W-1:0];
            in_src1_valid = (v1 != 0);
            in_src2       = s2[oc_pkg::REG_W-1:0];
            in_src2_valid = (v2 != 0);
            in_dst        = dst[oc_pkg::REG_W-1:0];
        end
    endtask

    task automatic queue_expect(input int port, input int warp, input int dst, input int op,
                                input logic [DW-1:0] s1, input logic [DW-1:0] s2);
        exp_port.push_back(port);
        exp_warp.push_back(warp);
        exp_dst.push_back(dst);
        exp_op.push_back(op);
        exp_src1.push_back(s1);
        exp_src2.push_back(s2);
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        @(negedge clk);
        in_valid = 1'b0;
        wb_en    = 1'b0;
        while (exp_warp.size() > 0 && waited < WAIT_MAX) begin
            @(posedge clk);                     // queue only changes on falling edges
            waited++;
        end
        if (exp_warp.size() > 0) begin
            $display("timeout: %0d expected dispatches never arrived", exp_warp.size());
            timeouts++;
            aborted = 1'b1;
        end
    endtask

    task automatic reject_line(input string line);
        $display("malformed stimulus line: %s", line);
        aborted = 1'b1;
    endtask

    initial begin
        string line;
        int fd, n, a, b, c, d, e, f, g;
        logic [NUM_LANES-1:0] mask;
        logic [DW-1:0] d1, d2;
        rst = 1'b1;
        in_valid = 1'b0;
        in_warp = '0;
        in_op = oc_pkg::op_alu;
        in_src1 = '0;
        in_src1_valid = 1'b0;
        in_src2 = '0;
        in_src2_valid = 1'b0;
        in_dst = '0;
        wb_en = 1'b0;
        wb_warp = '0;
        wb_reg = '0;
        wb_mask = '0;
        wb_data = '0;
        fd = $fopen("sim/oc_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file sim/oc_stimulus.txt");
            aborted = 1'b1;
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;
        while (fd != 0 && !aborted && $fgets(line, fd) > 0) begin
            case (line.getc(0))
                "W": begin
                    n = $sscanf(line, "W %d %d %h %h", a, b, mask, d1);
                    if (n == 4) write_register(a, b, mask, d1);
                    else reject_line(line);
                end
                "I": begin
                    n = $sscanf(line, "I %d %d %d %d %d %d %d", a, b, c, d, e, f, g);
                    if (n == 7) issue_instr(a, b, c, d, e, f, g);
                    else reject_line(line);
                end
                "E": begin
                    n = $sscanf(line, "E %d %d %d %d %h %h", a, b, c, d, d1, d2);
                    if (n == 6) queue_expect(a, b, c, d, d1, d2);
                    else reject_line(line);
                end
                "D": wait_drained();
                default: ;                      // comments and blank lines
            endcase
        end
        if (fd != 0)
            $fclose(fd);
        if (!aborted) begin
            wait_drained();
            repeat (4) @(negedge clk);          // room for a late duplicate dispatch
        end
        assert (full_seen) else begin
            $display("full never went high during the burst");
            other_errs++;
        end
        $display("summary: %0d wrong values, %0d unmatched, %0d missing, %0d timeouts, %0d other",
                 value_errs, stray_errs, exp_warp.size(), timeouts, other_errs);
        if (value_errs + stray_errs + exp_warp.size() + timeouts + other_errs == 0 && !aborted)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

/* sim/oc_stimulus.txt */
# W warp reg mask data | I warp op src1 v1 src2 v2 dst | op 0 alu, 1 load, 2 store
# E port(0 alu, 1 mem) warp dst op src1 src2 | D waits for dispatch | data lane 3 first
W 0 0 f 00000003000000020000000100000000
W 0 1 f 11000003110000021100000111000000
W 0 4 f 44000003440000024400000144000000
W 1 2 f 12000003120000021200000112000000
W 1 3 f 13000003130000021300000113000000
W 2 0 f 20000003200000022000000120000000
W 2 5 f 25000003250000022500000125000000
W 3 2 f 32000003320000023200000132000000
W 3 6 f 36000003360000023600000136000000
E 0 0 2 0 00000003000000020000000100000000 11000003110000021100000111000000
I 0 0 0 1 1 1 2
E 0 0 3 0 00000003000000020000000100000000 44000003440000024400000144000000
I 0 0 0 1 4 1 3
E 0 1 4 0 12000003120000021200000112000000 00000000000000000000000000000000
I 1 0 2 1 7 0 4
D
W 0 1 5 55000003550000025500000155000000
E 0 0 5 0 11000003550000021100000155000000 00000003000000020000000100000000
I 0 0 1 1 0 1 5
E 1 1 6 1 13000003130000021300000113000000 12000003120000021200000112000000
I 1 1 3 1 2 1 6
E 1 2 1 2 25000003250000022500000125000000 20000003200000022000000120000000
I 2 2 5 1 0 1 1
D
E 0 3 0 0 36000003360000023600000136000000 32000003320000023200000132000000
I 3 0 6 1 2 1 0
E 1 3 1 1 32000003320000023200000132000000 00000000000000000000000000000000
I 3 1 2 1 0 0 1
E 0 0 0 0 44000003440000024400000144000000 00000003000000020000000100000000
I 0 0 4 1 0 1 0
E 1 1 7 2 12000003120000021200000112000000 13000003130000021300000113000000
I 1 2 2 1 3 1 7
E 0 2 7 0 25000003250000022500000125000000 20000003200000022000000120000000
I 2 0 5 1 0 1 7
E 0 3 5 0 32000003320000023200000132000000 32000003320000023200000132000000
I 3 0 2 1 2 1 5
D
E 0 0 6 0 44000003440000024400000144000000 00000003000000020000000100000000
I 0 0 4 1 0 1 6
W 1 3 f 1b0000031b0000021b0000011b000000
W 2 2 f 22000003220000022200000122000000
E 0 1 1 0 1b0000031b0000021b0000011b000000 00000000000000000000000000000000
I 1 0 3 1 0 0 1
D

/* tb.f */
src/oc_pkg.sv
src/reg_banks.sv
src/collector_units.sv
src/dispatch_unit.sv
src/operand_collector.sv
sim/tb_operand_collector.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_operand_collector -f tb.f
	@out="$$(./obj_dir/Vtb_operand_collector)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^Regression passed$$'

clean:
	rm -rf obj_dir
